// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat files.f))

obj_dir/Vengine_tb: files.f $(SRCS)
	verilator --binary --assert -Wno-fatal -f files.f --top-module engine_tb -o Vengine_tb

run: obj_dir/Vengine_tb
	./obj_dir/Vengine_tb | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== files.f ====
logic/engine_cfg_pkg.sv
logic/engine_op_pkg.sv
logic/engine_decode.sv
logic/engine_mac_lanes.sv
logic/engine_result.sv
logic/engine_top.sv
tb/dma_mem_model.sv
tb/engine_tb.sv

// ==== logic/engine_cfg_pkg.sv ====
`default_nettype none

// Sizes shared by every block of the 1x1 convolution engine
package engine_cfg_pkg;

	// Word widths
	localparam int DATA_W = 16; // Data, weight and result words
	localparam int ADDR_W = 30; // DMA word address

	// Burst and lane geometry
	localparam int BURST_LEN  = 16; // Lane count, also the longest burst
	localparam int LANE_IDX_W = 5;  // Counts 0..BURST_LEN inclusive

	// Layer shape fields
	localparam int CHAN_W = 16; // Input and output channel counts
	localparam int SIDE_W = 8;  // Output side, pixels per row

	// Burst pair complete to group sum valid
	// Products, four-way adds, final add
	localparam int EXEC_LATENCY = 3;

	typedef logic [DATA_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

// ==== logic/engine_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

// Command check, layer loops and read burst issue
// Loop order is output channel, pixel, channel group
module engine_decode import engine_cfg_pkg::*, engine_op_pkg::*; (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    i_engine_valid,
	input  wire engine_op_t        i_op_type,
	input  wire [CHAN_W-1:0]       i_i_channel,
	input  wire [CHAN_W-1:0]       i_o_channel,
	input  wire [SIDE_W-1:0]       i_o_side,
	input  wire addr_t             i_data_start_addr,
	input  wire addr_t             i_weight_start_addr,
	input  wire                    i_pair_done,
	input  wire                    i_wb_done,
	output logic                   o_engine_ready,
	output logic                   o_cmd_err,
	output logic                   o_p2_rd_en,
	output logic                   o_p3_rd_en,
	output addr_t                  o_p2_addr,
	output addr_t                  o_p3_addr,
	output logic [LANE_IDX_W-1:0]  o_para,
	output logic                   o_grp_first,
	output logic                   o_grp_last
);

	engine_state_t           state;
	logic [CHAN_W-1:0]       ich_q;     // Latched input channel count
	logic [CHAN_W-1:0]       och_last;  // Output channels minus one
	logic [2*SIDE_W-1:0]     pix_last;  // o_side squared minus one
	logic [2*SIDE_W-1:0]     side_x;
	addr_t                   data_base;
	addr_t                   w_base;    // Weights of the current output channel
	logic [CHAN_W-1:0]       grp_off;   // First channel of the current group
	logic [CHAN_W-1:0]       grp_off_n;
	logic [2*SIDE_W-1:0]     pix_cnt;
	logic [CHAN_W-1:0]       oc_cnt;
	logic                    pair_pend; // Burst pair in flight
	logic                    cmd_ok;
	logic                    pix_wrap;
	logic                    layer_end;
	logic [LANE_IDX_W-1:0]   para_n;
	addr_t                   para_a;

	// Legal: conv, nonzero shape, channels 1..16 or whole groups of 16
	assign cmd_ok = (i_op_type == OP_CONV) && (i_o_side != '0) && (i_o_channel != '0)
		&& (i_i_channel != '0)
		&& ((i_i_channel <= CHAN_W'(BURST_LEN)) || (i_i_channel[LANE_IDX_W-2:0] == '0));

	assign para_n = (i_i_channel > CHAN_W'(BURST_LEN)) ? LANE_IDX_W'(BURST_LEN)
		: i_i_channel[LANE_IDX_W-1:0];
	assign side_x    = {{SIDE_W{1'b0}}, i_o_side};
	assign para_a    = ADDR_W'(o_para);
	assign grp_off_n = grp_off + CHAN_W'(o_para);
	assign pix_wrap  = (pix_cnt == pix_last);
	assign layer_end = pix_wrap && (oc_cnt == och_last);

	// Sequencer and loop counters
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state          <= ST_IDLE;
			o_engine_ready <= 1'b1;
			o_cmd_err      <= 1'b0;
			o_p2_rd_en     <= 1'b0;
			o_p3_rd_en     <= 1'b0;
			o_para         <= LANE_IDX_W'(BURST_LEN); // Never zero, lanes compare against it
			o_grp_first    <= 1'b0;
			o_grp_last     <= 1'b0;
			grp_off        <= '0;
			pix_cnt        <= '0;
			oc_cnt         <= '0;
			pair_pend      <= 1'b0;
		end else begin
			o_cmd_err  <= 1'b0; // Pulses
			o_p2_rd_en <= 1'b0;
			o_p3_rd_en <= 1'b0;
			if (o_p2_rd_en) pair_pend <= 1'b1;
			else if (i_pair_done) pair_pend <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (i_engine_valid && cmd_ok) begin
						o_engine_ready <= 1'b0;
						o_para         <= para_n;
						grp_off        <= '0;
						pix_cnt        <= '0;
						oc_cnt         <= '0;
						o_grp_first    <= 1'b1;
						o_grp_last     <= (i_i_channel <= CHAN_W'(BURST_LEN)); // One group
						o_p2_rd_en     <= 1'b1;
						o_p3_rd_en     <= 1'b1;
						state          <= ST_ISSUE;
					end else if (i_engine_valid) begin
						o_cmd_err <= 1'b1; // Rejected, stay idle
					end
				end
				ST_ISSUE: state <= ST_WAIT_BURST;
				ST_WAIT_BURST: begin
					if (i_pair_done && o_grp_last) begin
						state <= ST_WAIT_WB; // Next pixel waits for the write
					end else if (i_pair_done) begin
						grp_off     <= grp_off_n;
						o_grp_first <= 1'b0;
						o_grp_last  <= (grp_off_n + CHAN_W'(o_para) == ich_q);
						o_p2_rd_en  <= 1'b1;
						o_p3_rd_en  <= 1'b1;
						state       <= ST_ISSUE;
					end
				end
				ST_WAIT_WB: begin
					if (i_wb_done && layer_end) begin
						o_engine_ready <= 1'b1;
						state          <= ST_IDLE;
					end else if (i_wb_done) begin
						if (pix_wrap) begin
							pix_cnt <= '0;
							oc_cnt  <= oc_cnt + 1'b1;
						end else begin
							pix_cnt <= pix_cnt + 1'b1;
						end
						grp_off     <= '0;
						o_grp_first <= 1'b1;
						o_grp_last  <= (CHAN_W'(o_para) == ich_q);
						o_p2_rd_en  <= 1'b1;
						o_p3_rd_en  <= 1'b1;
						state       <= ST_ISSUE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Layer config and burst addresses
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && i_engine_valid && cmd_ok) begin
			ich_q     <= i_i_channel;
			och_last  <= i_o_channel - 1'b1;
			pix_last  <= side_x * side_x - 1'b1;
			data_base <= i_data_start_addr;
			w_base    <= i_weight_start_addr;
			o_p2_addr <= i_data_start_addr;
			o_p3_addr <= i_weight_start_addr;
		end else if (state == ST_WAIT_BURST && i_pair_done && !o_grp_last) begin
			o_p2_addr <= o_p2_addr + para_a; // Next group of the same pixel
			o_p3_addr <= o_p3_addr + para_a;
		end else if (state == ST_WAIT_WB && i_wb_done && !layer_end) begin
			if (pix_wrap) begin
				o_p2_addr <= data_base;          // Pixels start over
				o_p3_addr <= o_p3_addr + para_a; // Weights of the next output channel
				w_base    <= o_p3_addr + para_a;
			end else begin
				o_p2_addr <= o_p2_addr + para_a; // Pixels are packed back to back
				o_p3_addr <= w_base;
			end
		end
	end

	a_rd_one_cycle: assert property (@(posedge clk) disable iff (rst)
		(o_p2_rd_en || o_p3_rd_en) |=> !(o_p2_rd_en || o_p3_rd_en))
		else $error("read request longer than one cycle");

	// Lanes hold a single burst pair
	a_rd_single_pair: assert property (@(posedge clk) disable iff (rst)
		o_p2_rd_en |-> !pair_pend)
		else $error("read burst issued while a pair is outstanding");

endmodule

`default_nettype wire

// ==== logic/engine_mac_lanes.sv ====
`timescale 1ns/1ps
`default_nettype none

// Burst deserializer, 16 multipliers and a pipelined adder tree
module engine_mac_lanes import engine_cfg_pkg::*; (
	input  wire                    clk,
	input  wire                    rst,
	input  wire [LANE_IDX_W-1:0]   i_para,
	input  wire                    i_grp_first,
	input  wire                    i_grp_last,
	input  wire                    i_p2_we,
	input  wire                    i_p3_we,
	input  wire word_t             i_p2_data,
	input  wire word_t             i_p3_data,
	output logic                   o_pair_done,
	output logic                   o_sum_valid,
	output word_t                  o_sum,
	output logic                   o_sum_first,
	output logic                   o_sum_last
);

	word_t                    dbuf [BURST_LEN]; // Data burst
	word_t                    wbuf [BURST_LEN]; // Weight burst
	logic [LANE_IDX_W-1:0]    d_cnt;
	logic [LANE_IDX_W-1:0]    w_cnt;
	logic                     d_full;
	logic                     w_full;
	logic                     both_full;

	word_t                    lane_d [BURST_LEN];
	word_t                    lane_w [BURST_LEN];
	logic                     lane_first;
	logic                     lane_last;

	word_t                    prod [BURST_LEN];   // Stage one
	word_t                    part [BURST_LEN/4]; // Stage two
	logic [EXEC_LATENCY-1:0]  vld;
	logic [EXEC_LATENCY-1:0]  tag_first;
	logic [EXEC_LATENCY-1:0]  tag_last;

	assign d_full    = (d_cnt == i_para);
	assign w_full    = (w_cnt == i_para);
	assign both_full = d_full && w_full;

	// Word counters, pair done and valid pipe
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			d_cnt       <= '0;
			w_cnt       <= '0;
			o_pair_done <= 1'b0;
			vld         <= '0;
		end else begin
			o_pair_done <= both_full; // Lanes loaded on the same edge
			vld         <= {vld[EXEC_LATENCY-2:0], o_pair_done};
			if (both_full) d_cnt <= '0; // Buffers freed
			else if (i_p2_we) d_cnt <= d_cnt + 1'b1;
			if (both_full) w_cnt <= '0;
			else if (i_p3_we) w_cnt <= w_cnt + 1'b1;
		end
	end

	// Deserialize, one word per strobe
	always_ff @(posedge clk) begin
		if (i_p2_we && !d_full) dbuf[d_cnt[LANE_IDX_W-2:0]] <= i_p2_data;
		if (i_p3_we && !w_full) wbuf[w_cnt[LANE_IDX_W-2:0]] <= i_p3_data;
	end

	// Copy to lanes, unused lanes forced to zero
	always_ff @(posedge clk) begin
		if (both_full) begin
			for (int i = 0; i < BURST_LEN; i++) begin
				lane_d[i] <= (i < i_para) ? dbuf[i] : '0;
				lane_w[i] <= (i < i_para) ? wbuf[i] : '0;
			end
			lane_first <= i_grp_first; // Tags of the group just read
			lane_last  <= i_grp_last;
		end
	end

	// Tree stages run every cycle, vld marks the real ones
	always_ff @(posedge clk) begin
		for (int i = 0; i < BURST_LEN; i++) begin
			prod[i] <= lane_d[i] * lane_w[i]; // Low 16 bits kept
		end
		for (int j = 0; j < BURST_LEN/4; j++) begin
			part[j] <= prod[4*j] + prod[4*j+1] + prod[4*j+2] + prod[4*j+3];
		end
		o_sum     <= part[0] + part[1] + part[2] + part[3]; // Wraps at 16 bits
		tag_first <= {tag_first[EXEC_LATENCY-2:0], lane_first};
		tag_last  <= {tag_last[EXEC_LATENCY-2:0], lane_last};
	end

	assign o_sum_valid = vld[EXEC_LATENCY-1];
	assign o_sum_first = tag_first[EXEC_LATENCY-1];
	assign o_sum_last  = tag_last[EXEC_LATENCY-1];

	// DMA sends exactly para words per burst
	a_no_overfill: assert property (@(posedge clk) disable iff (rst)
		!((i_p2_we && d_full) || (i_p3_we && w_full)))
		else $error("DMA strobe on a full burst buffer");

endmodule

`default_nettype wire

// ==== logic/engine_op_pkg.sv ====
`default_nettype none

// Command encodings and sequencer states
package engine_op_pkg;

	// Operation field of a command
	// Pooling codes are still defined so that decode can reject them
	typedef enum logic [2:0] {
		OP_CONV  = 3'd1, // 1x1 convolution, the only one executed
		OP_MPOOL = 3'd4, // Max pooling
		OP_APOOL = 3'd5  // Average pooling
	} engine_op_t;

	// Layer sequencer in decode
	typedef enum logic [1:0] {
		ST_IDLE,       // Waiting for a command, ready high
		ST_ISSUE,      // Read pulse on p2/p3 this cycle
		ST_WAIT_BURST, // Burst pair outstanding
		ST_WAIT_WB     // Last group of a pixel issued, waiting on the p0 write
	} engine_state_t;

endpackage

`default_nettype wire

// ==== logic/engine_result.sv ====
`timescale 1ns/1ps
`default_nettype none

// Group accumulation and p0 write-back
module engine_result import engine_cfg_pkg::*; (
	input  wire         clk,
	input  wire         rst,
	input  wire         i_engine_valid,
	input  wire addr_t  i_result_start_addr,
	input  wire         i_sum_valid,
	input  wire word_t  i_sum,
	input  wire         i_sum_first,
	input  wire         i_sum_last,
	input  wire         i_p0_ib_re,
	output logic        o_p0_wr_en,
	output addr_t       o_p0_addr,
	output word_t       o_p0_ib_data,
	output logic        o_p0_ib_valid,
	output logic        o_wb_done
);

	word_t acc_q; // Running sum of the current pixel
	word_t total;

	// First group restarts the pixel sum
	assign total = i_sum_first ? i_sum : acc_q + i_sum;

	always_ff @(posedge clk) begin
		if (i_sum_valid) acc_q <= total;
		if (i_sum_valid && i_sum_last) o_p0_ib_data <= total; // Held until the write
	end

	// p0 sequence holds wr_en until re, then one ib_valid cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_p0_wr_en    <= 1'b0;
			o_p0_ib_valid <= 1'b0;
			o_p0_addr     <= '0;
		end else begin
			o_p0_ib_valid <= 1'b0;
			if (i_engine_valid) begin
				o_p0_addr <= i_result_start_addr;
			end else if (o_p0_ib_valid) begin
				o_p0_addr <= o_p0_addr + 1'b1; // Results are consecutive in loop order
			end
			if (i_sum_valid && i_sum_last) begin
				o_p0_wr_en <= 1'b1;
			end else if (o_p0_wr_en && i_p0_ib_re) begin
				o_p0_wr_en    <= 1'b0;
				o_p0_ib_valid <= 1'b1;
			end
		end
	end

	// Decode counts a pixel as written here
	assign o_wb_done = o_p0_ib_valid;

	// A sampled ib_re ends the request and gives one ib_valid cycle
	a_ib_after_re: assert property (@(posedge clk) disable iff (rst)
		(o_p0_wr_en && i_p0_ib_re) |=> (o_p0_ib_valid && !o_p0_wr_en))
		else $error("sampled ib_re not followed by ib_valid");

	// Decode holds the next pixel until the write is done
	a_no_wb_overrun: assert property (@(posedge clk) disable iff (rst)
		(i_sum_valid && i_sum_last) |-> !o_p0_wr_en)
		else $error("pixel result arrived while a write is pending");

endmodule

`default_nettype wire

// ==== logic/engine_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// Pointwise convolution engine, command in, DMA p0/p2/p3 out
module engine_top import engine_cfg_pkg::*, engine_op_pkg::*; (
	input  wire                clk,
	input  wire                rst,
	input  wire                i_engine_valid,
	input  wire engine_op_t    i_op_type,
	input  wire [CHAN_W-1:0]   i_i_channel,
	input  wire [CHAN_W-1:0]   i_o_channel,
	input  wire [SIDE_W-1:0]   i_o_side,
	input  wire addr_t         i_data_start_addr,
	input  wire addr_t         i_weight_start_addr,
	input  wire addr_t         i_result_start_addr,
	output logic               o_engine_ready,
	output logic               o_cmd_err,
	output logic               o_p0_wr_en,
	output addr_t              o_p0_addr,
	output word_t              o_p0_ib_data,
	output logic               o_p0_ib_valid,
	input  wire                i_p0_ib_re,
	output logic               o_p2_rd_en,
	output addr_t              o_p2_addr,
	input  wire                i_p2_we,
	input  wire word_t         i_p2_data,
	output logic               o_p3_rd_en,
	output addr_t              o_p3_addr,
	input  wire                i_p3_we,
	input  wire word_t         i_p3_data
);

	wire [LANE_IDX_W-1:0] para;
	wire                  grp_first, grp_last, pair_done, wb_done;
	wire                  sum_valid, sum_first, sum_last;
	word_t                sum;
	wire                  res_cmd_valid;

	// Busy engine ignores commands, result address included
	assign res_cmd_valid = i_engine_valid && o_engine_ready;

	engine_decode u_decode (
		.clk(clk), .rst(rst),
		.i_engine_valid(i_engine_valid), .i_op_type(i_op_type),
		.i_i_channel(i_i_channel), .i_o_channel(i_o_channel), .i_o_side(i_o_side),
		.i_data_start_addr(i_data_start_addr), .i_weight_start_addr(i_weight_start_addr),
		.i_pair_done(pair_done), .i_wb_done(wb_done),
		.o_engine_ready(o_engine_ready), .o_cmd_err(o_cmd_err),
		.o_p2_rd_en(o_p2_rd_en), .o_p3_rd_en(o_p3_rd_en),
		.o_p2_addr(o_p2_addr), .o_p3_addr(o_p3_addr),
		.o_para(para), .o_grp_first(grp_first), .o_grp_last(grp_last)
	);

	engine_mac_lanes u_mac_lanes (
		.clk(clk), .rst(rst),
		.i_para(para), .i_grp_first(grp_first), .i_grp_last(grp_last),
		.i_p2_we(i_p2_we), .i_p3_we(i_p3_we), .i_p2_data(i_p2_data), .i_p3_data(i_p3_data),
		.o_pair_done(pair_done), .o_sum_valid(sum_valid), .o_sum(sum),
		.o_sum_first(sum_first), .o_sum_last(sum_last)
	);

	engine_result u_result (
		.clk(clk), .rst(rst),
		.i_engine_valid(res_cmd_valid), .i_result_start_addr(i_result_start_addr),
		.i_sum_valid(sum_valid), .i_sum(sum), .i_sum_first(sum_first), .i_sum_last(sum_last),
		.i_p0_ib_re(i_p0_ib_re),
		.o_p0_wr_en(o_p0_wr_en), .o_p0_addr(o_p0_addr), .o_p0_ib_data(o_p0_ib_data),
		.o_p0_ib_valid(o_p0_ib_valid), .o_wb_done(wb_done)
	);

endmodule

`default_nettype wire

// ==== tb/dma_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

// DMA memory behind p0, p2 and p3 with random strobe gaps and re delays
module dma_mem_model import engine_cfg_pkg::*; (
	input  wire        clk,
	input  wire        rst,
	input  wire [4:0]  i_burst_len, // Words per read burst, para of the layer
	input  wire [3:0]  i_gap_bits,  // Gap before a strobe is below 2**bits cycles
	input  wire [3:0]  i_re_bits,   // Same for the ib_re delay
	input  wire        i_p2_rd_en,
	input  wire addr_t i_p2_addr,
	output logic       o_p2_we,
	output word_t      o_p2_data,
	input  wire        i_p3_rd_en,
	input  wire addr_t i_p3_addr,
	output logic       o_p3_we,
	output word_t      o_p3_data,
	input  wire        i_p0_wr_en,
	input  wire addr_t i_p0_addr,
	input  wire word_t i_p0_ib_data,
	input  wire        i_p0_ib_valid,
	output logic       o_p0_ib_re
);

	word_t       mem [4096]; // Word addresses fold onto 4K
	addr_t       log_addr [256];
	word_t       log_data [256];
	int          log_cnt;    // Writes seen so far
	logic [31:0] lfsr;
	int          epoch;      // Bumped by reset, stale bursts stop on it
	int          re_ep;
	int          re_delay;

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic int take_bits(input int n);
		int   v;
		logic fb;
		v = 0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = (v << 1) | int'(fb);
		end
		return v;
	endfunction

	// One burst on p2 or p3, every word after a random gap
	task automatic serve_burst(input bit port3, input addr_t base);
		int ep;
		int gap;
		ep = epoch;
		for (int k = 0; k < int'(i_burst_len); k++) begin
			gap = take_bits(int'(i_gap_bits));
			repeat (gap) @(negedge clk);
			if (ep != epoch) return; // Reset cut the burst
			if (port3) begin
				o_p3_we   = 1'b1;
				o_p3_data = mem[12'(base + addr_t'(k))];
			end else begin
				o_p2_we   = 1'b1;
				o_p2_data = mem[12'(base + addr_t'(k))];
			end
			@(negedge clk);
			o_p2_we = port3 ? o_p2_we : 1'b0; // Strobe lasts one cycle
			o_p3_we = port3 ? 1'b0 : o_p3_we;
		end
	endtask

	initial begin
		lfsr       = 32'hfdd6;
		epoch      = 0;
		log_cnt    = 0;
		o_p2_we    = 1'b0;
		o_p3_we    = 1'b0;
		o_p2_data  = '0;
		o_p3_data  = '0;
		o_p0_ib_re = 1'b0;
	end

	always @(posedge rst) epoch = epoch + 1;

	// Read requests seen at the falling edge
	always begin
		@(negedge clk);
		if (i_p2_rd_en && !rst) serve_burst(1'b0, i_p2_addr);
	end

	always begin
		@(negedge clk);
		if (i_p3_rd_en && !rst) serve_burst(1'b1, i_p3_addr);
	end

	// Write accept, ib_re after a random delay
	always begin
		@(negedge clk);
		if (i_p0_wr_en && !rst) begin
			re_ep    = epoch;
			re_delay = take_bits(int'(i_re_bits));
			repeat (re_delay) @(negedge clk);
			if (re_ep == epoch) begin
				o_p0_ib_re = 1'b1;
				@(negedge clk);
				o_p0_ib_re = 1'b0;
			end
		end
	end

	// Address still holds the write address while ib_valid is high
	always @(negedge clk) begin
		if (i_p0_ib_valid && !rst && log_cnt < 256) begin
			log_addr[log_cnt[7:0]] = i_p0_addr;
			log_data[log_cnt[7:0]] = i_p0_ib_data;
			log_cnt                = log_cnt + 1;
		end
	end

endmodule

`default_nettype wire

// ==== tb/engine_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

// Directed tests for the 1x1 convolution engine
module engine_tb import engine_cfg_pkg::*, engine_op_pkg::*; ();

	localparam int DATA_BASE   = 'h100;
	localparam int WEIGHT_BASE = 'h600;
	localparam int RESULT_BASE = 'h900;

	logic              clk;
	logic              rst;
	logic              engine_valid;
	engine_op_t        op_type;
	logic [CHAN_W-1:0] i_channel;
	logic [CHAN_W-1:0] o_channel;
	logic [SIDE_W-1:0] o_side;
	logic [4:0]        burst_len; // Model settings of the running layer
	logic [3:0]        gap_bits;
	logic [3:0]        re_bits;
	wire               engine_ready;
	wire               cmd_err;
	wire               p0_wr_en;
	wire               p0_ib_valid;
	wire               p0_ib_re;
	wire               p2_rd_en;
	wire               p2_we;
	wire               p3_rd_en;
	wire               p3_we;
	wire addr_t        p0_addr;
	wire addr_t        p2_addr;
	wire addr_t        p3_addr;
	wire word_t        p0_ib_data;
	wire word_t        p2_data;
	wire word_t        p3_data;
	word_t             exp_q [$]; // Golden results in loop order
	logic [31:0]       lfsr = 32'hfdd6;
	int unsigned       limit;

	engine_top u_engine_top (
		.clk(clk), .rst(rst), .i_engine_valid(engine_valid), .i_op_type(op_type),
		.i_i_channel(i_channel), .i_o_channel(o_channel), .i_o_side(o_side),
		.i_data_start_addr(addr_t'(DATA_BASE)), .i_weight_start_addr(addr_t'(WEIGHT_BASE)),
		.i_result_start_addr(addr_t'(RESULT_BASE)),
		.o_engine_ready(engine_ready), .o_cmd_err(cmd_err),
		.o_p0_wr_en(p0_wr_en), .o_p0_addr(p0_addr), .o_p0_ib_data(p0_ib_data),
		.o_p0_ib_valid(p0_ib_valid), .i_p0_ib_re(p0_ib_re),
		.o_p2_rd_en(p2_rd_en), .o_p2_addr(p2_addr), .i_p2_we(p2_we), .i_p2_data(p2_data),
		.o_p3_rd_en(p3_rd_en), .o_p3_addr(p3_addr), .i_p3_we(p3_we), .i_p3_data(p3_data)
	);

	dma_mem_model u_mem (
		.clk(clk), .rst(rst), .i_burst_len(burst_len), .i_gap_bits(gap_bits),
		.i_re_bits(re_bits),
		.i_p2_rd_en(p2_rd_en), .i_p2_addr(p2_addr), .o_p2_we(p2_we), .o_p2_data(p2_data),
		.i_p3_rd_en(p3_rd_en), .i_p3_addr(p3_addr), .o_p3_we(p3_we), .o_p3_data(p3_data),
		.i_p0_wr_en(p0_wr_en), .i_p0_addr(p0_addr), .i_p0_ib_data(p0_ib_data),
		.i_p0_ib_valid(p0_ib_valid), .o_p0_ib_re(p0_ib_re)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit
	function automatic int take_bits(input int n);
		int   v;
		logic fb;
		v = 0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = (v << 1) | int'(fb);
		end
		return v;
	endfunction

	// Worst case cycles of a layer with every group at its longest gaps and delay
	function automatic int layer_cycles(input int pix, input int och, input int grp,
		input int gap_b, input int re_b);
		return pix * och * grp * (2 * BURST_LEN * (1 << gap_b) + (1 << re_b) + 8) + 50;
	endfunction

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
			$display("Test failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// Random data and weights optionally pushed toward full scale
	task automatic fill_layer(input int ich, input int och, input int pix, input bit high);
		word_t v;
		for (int a = 0; a < pix * ich; a++) begin
			v = word_t'(take_bits(DATA_W));
			u_mem.mem[12'(DATA_BASE + a)] = high ? (v | 16'hf000) : v;
		end
		for (int a = 0; a < och * ich; a++) begin
			v = word_t'(take_bits(DATA_W));
			u_mem.mem[12'(WEIGHT_BASE + a)] = high ? (v | 16'he000) : v;
		end
	endtask

	task automatic build_expected(input int ich, input int och, input int pix);
		word_t       acc;
		logic [31:0] prod;
		exp_q.delete();
		for (int oc = 0; oc < och; oc++) begin
			for (int p = 0; p < pix; p++) begin
				acc = '0;
				for (int c = 0; c < ich; c++) begin
					prod = 32'(u_mem.mem[12'(DATA_BASE + p * ich + c)])
						* 32'(u_mem.mem[12'(WEIGHT_BASE + oc * ich + c)]);
					acc = acc + prod[15:0]; // Low half of the product and a wrapping sum
				end
				exp_q.push_back(acc);
			end
		end
	endtask

	// One cycle command pulse that returns on the falling edge after it
	task automatic send_cmd(input engine_op_t op, input int ich, input int och, input int side);
		@(negedge clk);
		engine_valid = 1'b1;
		op_type      = op;
		i_channel    = CHAN_W'(ich);
		o_channel    = CHAN_W'(och);
		o_side       = SIDE_W'(side);
		@(negedge clk);
		engine_valid = 1'b0;
	endtask

	task automatic run_layer(input string name, input int ich, input int och, input int side,
		input int gap_b, input int re_b, input bit high);
		burst_len = (ich > BURST_LEN) ? 5'(BURST_LEN) : 5'(ich);
		gap_bits  = 4'(gap_b);
		re_bits   = 4'(re_b);
		fill_layer(ich, och, side * side, high);
		build_expected(ich, och, side * side);
		u_mem.log_cnt = 0;
		check_eq(32'(engine_ready), 1, {name, ": ready before command"});
		send_cmd(OP_CONV, ich, och, side);
		check_eq(32'(engine_ready), 0, {name, ": ready drops on command"});
		while (!engine_ready) @(negedge clk); // Watchdog bounds this
		check_eq(32'(u_mem.log_cnt), exp_q.size(), {name, ": write count"});
		for (int k = 0; k < exp_q.size(); k++) begin
			check_eq(32'(u_mem.log_addr[k]), RESULT_BASE + k, $sformatf("%s: addr %0d", name, k));
			check_eq(32'(u_mem.log_data[k]), 32'(exp_q[k]), $sformatf("%s: data %0d", name, k));
		end
	endtask

	task automatic reject_cmd(input string name, input engine_op_t op, input int ich);
		send_cmd(op, ich, 2, 2);
		check_eq(32'(cmd_err), 1, {name, ": cmd_err pulse"});
		check_eq(32'(p2_rd_en || p3_rd_en), 0, {name, ": no read on reject"});
		repeat (20) begin
			@(negedge clk);
			check_eq(32'(p2_rd_en || p3_rd_en), 0, {name, ": no read after reject"});
			check_eq(32'(engine_ready), 1, {name, ": ready stays high"});
			check_eq(32'(cmd_err), 0, {name, ": cmd_err one cycle"});
		end
	endtask

	task automatic single_group();
		run_layer("single group", 4, 2, 2, 0, 0, 1'b0);
	endtask

	task automatic multi_group();
		run_layer("multi group", 48, 2, 2, 2, 1, 1'b0); // Three groups per pixel
	endtask

	task automatic write_backpressure();
		run_layer("write back-pressure", 16, 2, 3, 1, 5, 1'b0);
	endtask

	task automatic rejected_commands();
		reject_cmd("max pool", OP_MPOOL, 16);
		reject_cmd("20 channels", OP_CONV, 20);
	endtask

	task automatic wraparound_sums();
		run_layer("wraparound", 16, 1, 2, 1, 1, 1'b1);
	endtask

	task automatic reset_mid_layer();
		burst_len = 5'(BURST_LEN);
		gap_bits  = 4'd1;
		re_bits   = 4'd2;
		fill_layer(48, 2, 4, 1'b0);
		send_cmd(OP_CONV, 48, 2, 2);
		repeat (60) @(negedge clk);
		check_eq(32'(engine_ready), 0, "reset: layer still running");
		rst = 1'b1;
		repeat (3) @(negedge clk);
		check_eq(32'(engine_ready), 1, "reset: ready high");
		check_eq(32'(p2_rd_en || p3_rd_en), 0, "reset: no read");
		check_eq(32'(p0_wr_en || p0_ib_valid), 0, "reset: no write");
		check_eq(32'(cmd_err), 0, "reset: no cmd_err");
		rst = 1'b0;
		repeat (2) @(negedge clk);
		single_group();
	endtask

	// Watchdog sized from the tests in the order they run
	initial begin
		limit = layer_cycles(4, 2, 1, 0, 0) * 2 + layer_cycles(4, 2, 3, 2, 1)
			+ layer_cycles(9, 2, 1, 1, 5) + layer_cycles(4, 1, 1, 1, 1) + 400;
		repeat (limit) @(posedge clk);
		$display("Timeout: engine did not finish within %0d cycles", limit);
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		rst          = 1'b1;
		engine_valid = 1'b0;
		op_type      = OP_CONV;
		i_channel    = '0;
		o_channel    = '0;
		o_side       = '0;
		burst_len    = 5'(BURST_LEN);
		gap_bits     = '0;
		re_bits      = '0;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		single_group();
		multi_group();
		write_backpressure();
		rejected_commands();
		wraparound_sums();
		reset_mid_layer();
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire
